// ==== src/legIsaPkg.sv ====
package legIsaPkg;

  // datapath and address width
  localparam int XLEN = 64;
  // fixed 32-bit instruction word
  localparam int INSTR_WIDTH = 32;

  // register file geometry
  localparam int REG_COUNT = 32;
  localparam int REG_IDX_WIDTH = 5;
  // xzr, hard-wired zero
  localparam int ZERO_REG = 31;

  // decoded instruction class
  typedef enum logic [3:0] {
    opAdd, opSub, opAnd, opOrr, opEor,
    opAddi, opSubi, opAndi, opOrri, opEori,
    opLdur, opStur, opNop
  } instrOpE;

  // field positions within the instruction word
  localparam int OPC_HI = 31;
  localparam int OPC_LO = 21;
  localparam int RM_HI = 20;
  localparam int RM_LO = 16;
  localparam int IMM_HI = 21;
  localparam int IMM_LO = 10;
  localparam int DT_HI = 20;
  localparam int DT_LO = 12;
  localparam int RN_HI = 9;
  localparam int RN_LO = 5;
  localparam int RD_HI = 4;
  localparam int RD_LO = 0;

  // opcode field widths
  localparam int OPC_W = OPC_HI - OPC_LO + 1;
  // immediate forms only decode the upper ten opcode bits
  localparam int IMM_OPC_W = OPC_W - 1;

  // register forms, full 11-bit patterns
  localparam logic [OPC_W-1:0] OPC_ADD = 11'b10001011000;
  localparam logic [OPC_W-1:0] OPC_SUB = 11'b11001011000;
  localparam logic [OPC_W-1:0] OPC_AND = 11'b10001010000;
  localparam logic [OPC_W-1:0] OPC_ORR = 11'b10101010000;
  localparam logic [OPC_W-1:0] OPC_EOR = 11'b11001010000;
  // data transfer, d-format
  localparam logic [OPC_W-1:0] OPC_LDUR = 11'b11111000010;
  localparam logic [OPC_W-1:0] OPC_STUR = 11'b11111000000;

  // immediate forms, 10-bit patterns
  localparam logic [IMM_OPC_W-1:0] OPC_ADDI = 10'b1001000100;
  localparam logic [IMM_OPC_W-1:0] OPC_SUBI = 10'b1101000100;
  localparam logic [IMM_OPC_W-1:0] OPC_ANDI = 10'b1001001000;
  localparam logic [IMM_OPC_W-1:0] OPC_ORRI = 10'b1011001000;
  localparam logic [IMM_OPC_W-1:0] OPC_EORI = 10'b1101001000;

endpackage

// ==== src/pipeCtrlPkg.sv ====
package pipeCtrlPkg;

  // alu function carried from decode into execute
  // add also serves the ldur/stur address sum
  typedef enum logic [2:0] {
    aluAdd,
    // inverted operand plus carry-in
    aluSub,
    aluAnd,
    aluOr,
    aluXor
  } aluOpE;

  // memory access kind, carried through to the mem stage
  typedef enum logic [1:0] {
    // no access, plain alu op or nop
    memNone,
    // ldur, result comes from loadData
    memLoad,
    // stur, rt goes out on storeData
    memStore
  } memOpE;

endpackage

// ==== src/fetchDecode.sv ====
module fetchDecode #(
  parameter logic [legIsaPkg::XLEN-1:0] ResetPc = '0
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [legIsaPkg::INSTR_WIDTH-1:0]    instr,
  input  logic [legIsaPkg::XLEN-1:0]           rdDataA,
  input  logic [legIsaPkg::XLEN-1:0]           rdDataB,
  output logic [legIsaPkg::XLEN-1:0]           instrAddr,
  output logic [legIsaPkg::REG_IDX_WIDTH-1:0]  rdIdxA,
  output logic [legIsaPkg::REG_IDX_WIDTH-1:0]  rdIdxB,
  output logic [legIsaPkg::XLEN-1:0]           opA,
  output logic [legIsaPkg::XLEN-1:0]           opB,
  output logic [legIsaPkg::XLEN-1:0]           imm,
  output logic                                 useImm,
  output logic [legIsaPkg::REG_IDX_WIDTH-1:0]  dest,
  output logic                                 wrEn,
  output pipeCtrlPkg::aluOpE                   aluOp,
  output pipeCtrlPkg::memOpE                   memOp
);
  import legIsaPkg::*;
  import pipeCtrlPkg::*;

  logic [XLEN-1:0] pc;
  // if/id register
  logic [INSTR_WIDTH-1:0] instrQ;
  logic [OPC_W-1:0] opcode;
  instrOpE instrOp;
  logic [XLEN-1:0] aluImm;
  logic [XLEN-1:0] xferOfs;

  // pc and if/id, reset loads a nop
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= ResetPc;
      instrQ <= '0;
    end else begin
      // straight-line fetch, no redirect
      pc <= pc + XLEN'(4);
      instrQ <= instr;
    end
  end

  assign instrAddr = pc;
  assign opcode = instrQ[OPC_HI:OPC_LO];

  // opcode classify
  // immediate forms ignore opcode bit 21
  always_comb begin
    casez (opcode)
      OPC_ADD: instrOp = opAdd;
      OPC_SUB: instrOp = opSub;
      OPC_AND: instrOp = opAnd;
      OPC_ORR: instrOp = opOrr;
      OPC_EOR: instrOp = opEor;
      {OPC_ADDI, 1'b?}: instrOp = opAddi;
      {OPC_SUBI, 1'b?}: instrOp = opSubi;
      {OPC_ANDI, 1'b?}: instrOp = opAndi;
      {OPC_ORRI, 1'b?}: instrOp = opOrri;
      {OPC_EORI, 1'b?}: instrOp = opEori;
      OPC_LDUR: instrOp = opLdur;
      OPC_STUR: instrOp = opStur;
      // all-zero word and anything unknown
      default: instrOp = opNop;
    endcase
  end

  // class to alu function
  always_comb begin
    case (instrOp)
      opSub, opSubi: aluOp = aluSub;
      opAnd, opAndi: aluOp = aluAnd;
      opOrr, opOrri: aluOp = aluOr;
      opEor, opEori: aluOp = aluXor;
      // add, addi, and the ldur/stur address sum
      default: aluOp = aluAdd;
    endcase
  end

  // class to memory access
  always_comb begin
    case (instrOp)
      opLdur: memOp = memLoad;
      opStur: memOp = memStore;
      default: memOp = memNone;
    endcase
  end

  // stores and nops leave the register file alone
  assign wrEn = !(instrOp inside {opStur, opNop});
  assign useImm = instrOp inside {opAddi, opSubi, opAndi, opOrri, opEori, opLdur, opStur};

  // 12-bit alu immediate, zero extended
  assign aluImm = {{(XLEN - (IMM_HI - IMM_LO + 1)){1'b0}}, instrQ[IMM_HI:IMM_LO]};
  // 9-bit byte offset, sign extended
  assign xferOfs = {{(XLEN - (DT_HI - DT_LO + 1)){instrQ[DT_HI]}}, instrQ[DT_HI:DT_LO]};
  // loads and stores always take the offset
  assign imm = (instrOp inside {opLdur, opStur}) ? xferOfs : aluImm;

  // port a reads rn
  assign rdIdxA = instrQ[RN_HI:RN_LO];
  // stur reads rt on port b as store data, others read rm
  assign rdIdxB = (instrOp == opStur) ? instrQ[RD_HI:RD_LO] : instrQ[RM_HI:RM_LO];
  // rd for alu ops, rt for ldur
  assign dest = instrQ[RD_HI:RD_LO];

  // register values go straight on to the id/ex register
  assign opA = rdDataA;
  assign opB = rdDataB;

  // sequential fetch, one word per cycle
  assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> (pc == $past(pc) + XLEN'(4)))
    else $error("pc did not advance by 4");

endmodule

// ==== src/regFile.sv ====
module regFile (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [legIsaPkg::REG_IDX_WIDTH-1:0]  rdIdxA,
  input  logic [legIsaPkg::REG_IDX_WIDTH-1:0]  rdIdxB,
  output logic [legIsaPkg::XLEN-1:0]           rdDataA,
  output logic [legIsaPkg::XLEN-1:0]           rdDataB,
  input  logic [legIsaPkg::REG_IDX_WIDTH-1:0]  wrIdx,
  input  logic [legIsaPkg::XLEN-1:0]           wrData,
  input  logic                                 wrEn
);
  import legIsaPkg::*;

  // storage for x0..x30 only
  logic [XLEN-1:0] regs [REG_COUNT-1];
  logic wrLive;

  // writes aimed at xzr are dropped here
  assign wrLive = wrEn && (wrIdx != REG_IDX_WIDTH'(ZERO_REG));

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < REG_COUNT - 1; i++) begin
        regs[i] <= '0;
      end
    end else if (wrLive) begin
      regs[wrIdx] <= wrData;
    end
  end

  // zero index wins over the write-through path
  // same-cycle write shows through ahead of the stored value
  assign rdDataA = (rdIdxA == REG_IDX_WIDTH'(ZERO_REG)) ? '0 :
                   (wrLive && (wrIdx == rdIdxA)) ? wrData : regs[rdIdxA];
  assign rdDataB = (rdIdxB == REG_IDX_WIDTH'(ZERO_REG)) ? '0 :
                   (wrLive && (wrIdx == rdIdxB)) ? wrData : regs[rdIdxB];

  // xzr reads stay zero even while writeback targets it
  assert property (@(posedge clk) disable iff (rst)
    ((rdIdxA == REG_IDX_WIDTH'(ZERO_REG)) |-> (rdDataA == '0)) and
    ((rdIdxB == REG_IDX_WIDTH'(ZERO_REG)) |-> (rdDataB == '0)))
    else $error("nonzero read of xzr");

endmodule

// ==== src/execStage.sv ====
module execStage (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [legIsaPkg::XLEN-1:0]           opA,
  input  logic [legIsaPkg::XLEN-1:0]           opB,
  input  logic [legIsaPkg::XLEN-1:0]           imm,
  input  logic                                 useImm,
  input  logic [legIsaPkg::REG_IDX_WIDTH-1:0]  dest,
  input  logic                                 wrEn,
  input  pipeCtrlPkg::aluOpE                   aluOp,
  input  pipeCtrlPkg::memOpE                   memOp,
  output logic [legIsaPkg::XLEN-1:0]           result,
  output logic [legIsaPkg::XLEN-1:0]           storeVal,
  output logic [legIsaPkg::REG_IDX_WIDTH-1:0]  destOut,
  output logic                                 wrEnOut,
  output pipeCtrlPkg::memOpE                   memOpOut
);
  import legIsaPkg::*;
  import pipeCtrlPkg::*;

  // id/ex payload
  logic [XLEN-1:0] opAQ;
  logic [XLEN-1:0] opBQ;
  logic [XLEN-1:0] immQ;
  logic [REG_IDX_WIDTH-1:0] destQ;
  // id/ex control
  logic useImmQ;
  logic wrEnQ;
  aluOpE aluOpQ;
  memOpE memOpQ;

  logic [XLEN-1:0] operandB;
  logic subtract;
  logic [XLEN-1:0] addend;
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] aluRes;

  always_ff @(posedge clk) begin
    opAQ <= opA;
    opBQ <= opB;
    immQ <= imm;
    destQ <= dest;
    if (rst) begin
      useImmQ <= 1'b0;
      wrEnQ <= 1'b0;
      aluOpQ <= aluAdd;
      memOpQ <= memNone;
    end else begin
      useImmQ <= useImm;
      wrEnQ <= wrEn;
      aluOpQ <= aluOp;
      memOpQ <= memOp;
    end
  end

  // second operand, immediate or register
  assign operandB = useImmQ ? immQ : opBQ;

  // single adder, sub as a + ~b + 1
  assign subtract = (aluOpQ == aluSub);
  assign addend = subtract ? ~operandB : operandB;
  assign sum = opAQ + addend + {{(XLEN - 1){1'b0}}, subtract};

  always_comb begin
    case (aluOpQ)
      aluAnd: aluRes = opAQ & operandB;
      aluOr: aluRes = opAQ | operandB;
      aluXor: aluRes = opAQ ^ operandB;
      // add and sub share the adder
      default: aluRes = sum;
    endcase
  end

  // ex/mem register
  always_ff @(posedge clk) begin
    result <= aluRes;
    // rt value for stur, read on port b
    storeVal <= opBQ;
    destOut <= destQ;
    if (rst) begin
      wrEnOut <= 1'b0;
      memOpOut <= memNone;
    end else begin
      wrEnOut <= wrEnQ;
      memOpOut <= memOpQ;
    end
  end

  // decode must always hand over a defined alu function
  assert property (@(posedge clk) disable iff (rst) !$isunknown(aluOp))
    else $error("unknown alu op from decode");

endmodule

// ==== src/resultStage.sv ====
module resultStage (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [legIsaPkg::XLEN-1:0]           result,
  input  logic [legIsaPkg::XLEN-1:0]           storeVal,
  input  logic [legIsaPkg::REG_IDX_WIDTH-1:0]  dest,
  input  logic                                 wrEn,
  input  pipeCtrlPkg::memOpE                   memOp,
  input  logic [legIsaPkg::XLEN-1:0]           loadData,
  output logic [legIsaPkg::XLEN-1:0]           dataAddr,
  output logic [legIsaPkg::XLEN-1:0]           storeData,
  output logic                                 storeEn,
  output logic                                 loadEn,
  output logic [legIsaPkg::REG_IDX_WIDTH-1:0]  wrIdx,
  output logic [legIsaPkg::XLEN-1:0]           wrData,
  output logic                                 wrEnOut
);
  import pipeCtrlPkg::*;

  // mem stage, straight off the ex/mem register
  // alu sum is the byte address
  assign dataAddr = result;
  assign storeData = storeVal;
  // one-cycle strobes, no handshake
  assign storeEn = (memOp == memStore);
  assign loadEn = (memOp == memLoad);

  // mem/wb register
  always_ff @(posedge clk) begin
    wrIdx <= dest;
    // memory answers in the same cycle as loadEn
    wrData <= loadEn ? loadData : result;
    if (rst) begin
      wrEnOut <= 1'b0;
    end else begin
      wrEnOut <= wrEn;
    end
  end

  // one access kind per cycle on the split bus
  assert property (@(posedge clk) disable iff (rst) !(storeEn && loadEn))
    else $error("load and store strobes high together");

endmodule

// ==== src/legCore.sv ====
module legCore #(
  parameter logic [legIsaPkg::XLEN-1:0] ResetPc = '0
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [legIsaPkg::INSTR_WIDTH-1:0]  instr,
  output logic [legIsaPkg::XLEN-1:0]         instrAddr,
  output logic [legIsaPkg::XLEN-1:0]         dataAddr,
  output logic [legIsaPkg::XLEN-1:0]         storeData,
  output logic                               storeEn,
  output logic                               loadEn,
  input  logic [legIsaPkg::XLEN-1:0]         loadData
);
  import legIsaPkg::*;
  import pipeCtrlPkg::*;

  // register file read side
  logic [REG_IDX_WIDTH-1:0] rdIdxA;
  logic [REG_IDX_WIDTH-1:0] rdIdxB;
  logic [XLEN-1:0] rdDataA;
  logic [XLEN-1:0] rdDataB;

  // decode to execute
  logic [XLEN-1:0] opA;
  logic [XLEN-1:0] opB;
  logic [XLEN-1:0] imm;
  logic useImm;
  logic [REG_IDX_WIDTH-1:0] dest;
  logic wrEn;
  aluOpE aluOp;
  memOpE memOp;

  // execute to mem
  logic [XLEN-1:0] exResult;
  logic [XLEN-1:0] exStoreVal;
  logic [REG_IDX_WIDTH-1:0] exDest;
  logic exWrEn;
  memOpE exMemOp;

  // writeback into the register file
  logic [REG_IDX_WIDTH-1:0] wbIdx;
  logic [XLEN-1:0] wbData;
  logic wbEn;

  fetchDecode #(.ResetPc(ResetPc)) fetchDecodeInst (
    .clk(clk), .rst(rst), .instr(instr),
    .rdDataA(rdDataA), .rdDataB(rdDataB),
    .instrAddr(instrAddr), .rdIdxA(rdIdxA), .rdIdxB(rdIdxB),
    .opA(opA), .opB(opB), .imm(imm), .useImm(useImm),
    .dest(dest), .wrEn(wrEn), .aluOp(aluOp), .memOp(memOp)
  );

  regFile regFileInst (
    .clk(clk), .rst(rst),
    .rdIdxA(rdIdxA), .rdIdxB(rdIdxB), .rdDataA(rdDataA), .rdDataB(rdDataB),
    .wrIdx(wbIdx), .wrData(wbData), .wrEn(wbEn)
  );

  execStage execStageInst (
    .clk(clk), .rst(rst),
    .opA(opA), .opB(opB), .imm(imm), .useImm(useImm),
    .dest(dest), .wrEn(wrEn), .aluOp(aluOp), .memOp(memOp),
    .result(exResult), .storeVal(exStoreVal), .destOut(exDest),
    .wrEnOut(exWrEn), .memOpOut(exMemOp)
  );

  resultStage resultStageInst (
    .clk(clk), .rst(rst),
    .result(exResult), .storeVal(exStoreVal), .dest(exDest),
    .wrEn(exWrEn), .memOp(exMemOp), .loadData(loadData),
    .dataAddr(dataAddr), .storeData(storeData),
    .storeEn(storeEn), .loadEn(loadEn),
    .wrIdx(wbIdx), .wrData(wbData), .wrEnOut(wbEn)
  );

endmodule

// ==== bench/legStimulus.sv ====
module legStimulus #(
  parameter int NumSlots = 300
) (
  input  logic                               clk,
  input  logic                               rst,
  output logic [legIsaPkg::INSTR_WIDTH-1:0]  instr,
  output logic                               expValid,
  output logic                               expStore,
  output logic [legIsaPkg::XLEN-1:0]         expAddr,
  output logic [legIsaPkg::XLEN-1:0]         expData,
  output logic                               done
);
  timeunit 1ns;
  timeprecision 100ps;
  import legIsaPkg::*;

  localparam logic [OPC_W-1:0] regOpc [5] = '{OPC_ADD, OPC_SUB, OPC_AND, OPC_ORR, OPC_EOR};
  localparam logic [IMM_OPC_W-1:0] immOpc [5] = '{OPC_ADDI, OPC_SUBI, OPC_ANDI, OPC_ORRI, OPC_EORI};

  // reference registers, updated in issue order
  logic [XLEN-1:0] refRegs [REG_COUNT];
  // slot of the last write per register
  int lastWr [REG_COUNT];

  // data memory contents, every address bit matters
  function automatic logic [XLEN-1:0] memWord(input logic [XLEN-1:0] addr);
    return (addr * 64'h9e3779b97f4a7c15) ^ {addr[31:0], addr[63:32]};
  endfunction

  // mostly x0..x7, now and then xzr
  function automatic logic [REG_IDX_WIDTH-1:0] pickReg();
    return ($urandom_range(0, 15) == 0) ? 5'd31 : 5'($urandom_range(0, 7));
  endfunction

  initial begin
    int slot;
    int count;
    int kind;
    logic [REG_IDX_WIDTH-1:0] rd;
    logic [REG_IDX_WIDTH-1:0] rn;
    logic [REG_IDX_WIDTH-1:0] rm;
    logic [11:0] imm12;
    logic [8:0] ofs;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] res;
    logic [XLEN-1:0] addr;
    logic [INSTR_WIDTH-1:0] word;
    void'($urandom(32'h298b49ee));
    instr = '0;
    expValid = 1'b0;
    expStore = 1'b0;
    expAddr = '0;
    expData = '0;
    done = 1'b0;
    for (int i = 0; i < REG_COUNT; i++) begin
      refRegs[i] = '0;
      lastWr[i] = -10;
    end
    slot = 0;
    count = 0;
    wait (!rst);
    while (slot < NumSlots) begin
      rd = pickReg();
      rn = pickReg();
      rm = pickReg();
      imm12 = 12'($urandom);
      ofs = 9'($urandom);
      // 0..4 register forms, 5..9 immediate forms, 10 ldur, 11..13 stur
      kind = $urandom_range(0, 13);
      // first eight fill x0..x7 with addi from xzr
      if (count < 8) begin
        kind = 5;
        rd = 5'(count);
        rn = 5'd31;
      end
      // rm doubles as rt for stur, unused otherwise
      if (kind >= 5 && kind <= 10) begin
        rm = 5'd31;
      end
      a = refRegs[rn];
      b = (kind < 5) ? refRegs[rm] : 64'(imm12);
      case (kind % 5)
        0: res = a + b;
        1: res = a - b;
        2: res = a & b;
        3: res = a | b;
        default: res = a ^ b;
      endcase
      addr = a + {{(XLEN - 9){ofs[8]}}, ofs};
      if (kind < 5) begin
        word = {regOpc[kind], rm, 6'b0, rn, rd};
      end else if (kind < 10) begin
        word = {immOpc[kind - 5], imm12, rn, rd};
      end else if (kind == 10) begin
        word = {OPC_LDUR, ofs, 2'b00, rn, rd};
        res = memWord(addr);
      end else begin
        word = {OPC_STUR, ofs, 2'b00, rn, rm};
      end
      // nops or unknown words until both sources are three slots old
      while (slot < NumSlots && (slot < lastWr[rn] + 3 || slot < lastWr[rm] + 3)) begin
        @(negedge clk);
        instr = ($urandom_range(0, 1) == 0) ? '0 : {3'b000, 29'($urandom)};
        expValid = 1'b0;
        slot++;
      end
      if (slot < NumSlots) begin
        @(negedge clk);
        instr = word;
        expValid = (kind >= 10);
        expStore = (kind > 10);
        expAddr = addr;
        expData = refRegs[rm];
        // stores and xzr targets leave the reference alone
        if (kind <= 10 && rd != 5'd31) begin
          refRegs[rd] = res;
          lastWr[rd] = slot;
        end
        slot++;
        count++;
      end
    end
    // drain the pipe
    repeat (6) begin
      @(negedge clk);
      instr = '0;
      expValid = 1'b0;
    end
    done = 1'b1;
  end

endmodule

// ==== bench/legCoreTb.sv ====
module legCoreTb;
  timeunit 1ns;
  timeprecision 100ps;
  import legIsaPkg::*;

  localparam int NumSlots = 400;
  localparam logic [XLEN-1:0] StartPc = 64'h1000;

  logic clk;
  logic rst;
  logic [INSTR_WIDTH-1:0] instr;
  logic [XLEN-1:0] instrAddr;
  logic [XLEN-1:0] dataAddr;
  logic [XLEN-1:0] storeData;
  logic storeEn;
  logic loadEn;
  logic [XLEN-1:0] loadData;

  // expected accesses from the stimulus
  logic expValid;
  logic expStore;
  logic [XLEN-1:0] expAddr;
  logic [XLEN-1:0] expData;
  logic done;

  // access fifo, one entry per ldur/stur issued
  logic [XLEN-1:0] addrQ [NumSlots];
  logic [XLEN-1:0] dataQ [NumSlots];
  logic storeQ [NumSlots];
  int wrPtr = 0;
  int rdPtr = 0;
  int cycleCount = 0;
  logic hasEntry;
  logic access;

  legCore #(.ResetPc(StartPc)) UUT (
    .clk(clk), .rst(rst), .instr(instr), .instrAddr(instrAddr),
    .dataAddr(dataAddr), .storeData(storeData),
    .storeEn(storeEn), .loadEn(loadEn), .loadData(loadData)
  );

  legStimulus #(.NumSlots(NumSlots)) stim (
    .clk(clk), .rst(rst), .instr(instr),
    .expValid(expValid), .expStore(expStore), .expAddr(expAddr), .expData(expData),
    .done(done)
  );

  // combinational data memory
  assign loadData = stim.memWord(dataAddr);

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= rst ? 0 : cycleCount + 1;
    if (expValid) begin
      addrQ[wrPtr] <= expAddr;
      dataQ[wrPtr] <= expData;
      storeQ[wrPtr] <= expStore;
      wrPtr <= wrPtr + 1;
    end
    if (!rst && access && hasEntry) begin
      rdPtr <= rdPtr + 1;
    end
  end

  assign hasEntry = (rdPtr != wrPtr);
  assign access = storeEn || loadEn;

  // pc starts at the reset address, then one word per cycle
  assert property (@(posedge clk) disable iff (rst)
    instrAddr == StartPc + 64'(4 * cycleCount))
    else abortRun($sformatf("Error at %0d ns: instrAddr %h, expected %h", $time,
      $sampled(instrAddr), StartPc + 64'(4 * $sampled(cycleCount))));
  // no strobe without an outstanding access
  assert property (@(posedge clk) disable iff (rst) access |-> hasEntry)
    else abortRun($sformatf("Error at %0d ns: memory strobe with no access due", $time));
  assert property (@(posedge clk) disable iff (rst)
    (access && hasEntry) |-> (storeEn == storeQ[rdPtr]))
    else abortRun($sformatf("Error at %0d ns: storeEn %b, expected %b", $time,
      $sampled(storeEn), $sampled(storeQ[rdPtr])));
  assert property (@(posedge clk) disable iff (rst)
    (access && hasEntry) |-> (dataAddr == addrQ[rdPtr]))
    else abortRun($sformatf("Error at %0d ns: dataAddr %h, expected %h", $time,
      $sampled(dataAddr), $sampled(addrQ[rdPtr])));
  // store data covers alu results, loaded values and xzr
  assert property (@(posedge clk) disable iff (rst)
    (storeEn && hasEntry) |-> (storeData == dataQ[rdPtr]))
    else abortRun($sformatf("Error at %0d ns: storeData %h, expected %h", $time,
      $sampled(storeData), $sampled(dataQ[rdPtr])));

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    wait (done);
    if (hasEntry) begin
      abortRun($sformatf("%0d expected memory accesses never reached the memory ports",
        wrPtr - rdPtr));
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

  // watchdog, program length plus slack for reset and drain
  initial begin
    #((NumSlots + 20) * 4);
    abortRun("watchdog expired before the program finished");
  end

endmodule

// ==== build.f ====
src/legIsaPkg.sv
src/pipeCtrlPkg.sv
src/fetchDecode.sv
src/regFile.sv
src/execStage.sv
src/resultStage.sv
src/legCore.sv
bench/legStimulus.sv
bench/legCoreTb.sv

// ==== Bender.yml ====
package:
  name: leg_core

sources:
  - files:
      - src/legIsaPkg.sv
      - src/pipeCtrlPkg.sv
      - src/fetchDecode.sv
      - src/regFile.sv
      - src/execStage.sv
      - src/resultStage.sv
      - src/legCore.sv
  - target: test
    files:
      - bench/legStimulus.sv
      - bench/legCoreTb.sv
